/* src/stream_params.svh */
// widths and buffer depths shared by the whole memory endpoint
// the block must be a power-of-two multiple of the data beat
// memory depth sets how many byte address bits select a word
`ifndef STREAM_PARAMS_SVH
`define STREAM_PARAMS_SVH

// one stream beat carries a 64-bit word
`define STREAM_DATA_W 64
// largest payload a single message may describe
`define STREAM_BLOCK_W 256
// byte address width of request and response headers
`define STREAM_ADDR_W 16
// number of 64-bit words in the backing memory
`define STREAM_MEM_WORDS 32
// buffer depths, headers are counted per message and data per beat
`define STREAM_HDR_ELS 2
`define STREAM_DATA_ELS 8

// derived values, words per block and the beat counter that indexes them
`define STREAM_BLOCK_WORDS (`STREAM_BLOCK_W / `STREAM_DATA_W)
`define STREAM_CNT_W $clog2(`STREAM_BLOCK_WORDS)

`endif

/* src/stream_pkg.sv */
// types shared by the pump, the memory controller and the testbench
// message sizes above one block (size 5) are not supported
// there is no byte masking, every write stores a whole word

`include "stream_params.svh"

package stream_pkg;

  // one data beat on the stream
  typedef logic [`STREAM_DATA_W-1:0] data_t;

  // byte address carried in headers
  typedef logic [`STREAM_ADDR_W-1:0] addr_t;

  // index of a word inside the block
  typedef logic [`STREAM_CNT_W-1:0] beat_cnt_t;

  // log2 of the payload in bytes, 3 to 5 are legal
  typedef logic [2:0] msg_size_t;

  // the only two message kinds the endpoint understands
  typedef enum logic
  {
    e_msg_rd = 1'b0,
    e_msg_wr = 1'b1
  } msg_type_e;

  // request header, repeated on every beat of a message
  typedef struct packed
  {
    msg_type_e msg_type;
    addr_t     addr;
    msg_size_t size;
  } msg_header_s;

  // response header
  // reads carry the word address of the beat
  // write acks carry the original message address
  typedef struct packed
  {
    msg_type_e msg_type;
    addr_t     addr;
  } resp_header_s;

  // memory controller states, tracks whether a response beat is held
  typedef enum logic
  {
    e_idle = 1'b0,
    e_resp = 1'b1
  } ctrl_state_e;

endpackage

/* src/stream_fifo.sv */
// buffers a valid/ready-and message stream in two circular queues
// the header is sampled from the first beat only, later copies are ignored
// input ready stays low during reset and while either queue is full
`timescale 1ns/1ps
`include "stream_params.svh"

module stream_fifo
  #(
    parameter int hdr_els_p  = `STREAM_HDR_ELS,
    parameter int data_els_p = `STREAM_DATA_ELS
  )
  (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  stream_pkg::msg_header_s  msg_header_i,
    input  stream_pkg::data_t        msg_data_i,
    input  logic                     msg_v_i,
    input  logic                     msg_last_i,
    output logic                     msg_ready_and_o,
    output stream_pkg::msg_header_s  msg_header_o,
    output stream_pkg::data_t        msg_data_o,
    output logic                     msg_v_o,
    output logic                     msg_last_o,
    input  logic                     msg_ready_and_i
  );
  import stream_pkg::*;

  localparam int hdr_ptr_w  = (hdr_els_p > 1) ? $clog2(hdr_els_p) : 1;
  localparam int data_ptr_w = (data_els_p > 1) ? $clog2(data_els_p) : 1;
  localparam int hdr_cnt_w  = $clog2(hdr_els_p + 1);
  localparam int data_cnt_w = $clog2(data_els_p + 1);

  // a data entry keeps its last flag next to the word
  typedef struct packed
  {
    logic  last;
    data_t data;
  } beat_s;

  msg_header_s           hdr_mem [hdr_els_p];
  beat_s                 data_mem [data_els_p];
  logic [hdr_ptr_w-1:0]  hdr_wr_ptr_r, hdr_rd_ptr_r;
  logic [data_ptr_w-1:0] data_wr_ptr_r, data_rd_ptr_r;
  logic [hdr_cnt_w-1:0]  hdr_cnt_r;
  logic [data_cnt_w-1:0] data_cnt_r;
  logic                  in_msg_r;
  logic                  enq, deq, hdr_enq, hdr_deq;

  // either queue full blocks the whole input
  // nothing is accepted while reset is held
  assign msg_ready_and_o = ~rst_i
                         & (hdr_cnt_r != hdr_cnt_w'(hdr_els_p))
                         & (data_cnt_r != data_cnt_w'(data_els_p));
  assign enq = msg_v_i & msg_ready_and_o;

  // a header goes in only when no message is partly received
  assign hdr_enq = enq & ~in_msg_r;

  // a beat is visible one cycle after it was written
  assign msg_v_o = (data_cnt_r != '0);
  assign deq     = msg_v_o & msg_ready_and_i;

  // the header leaves together with the last beat of its message
  assign hdr_deq = deq & msg_last_o;

  assign msg_header_o = hdr_mem[hdr_rd_ptr_r];
  assign msg_data_o   = data_mem[data_rd_ptr_r].data;
  assign msg_last_o   = data_mem[data_rd_ptr_r].last;

  // storage itself has no reset, the counts say what is valid
  always_ff @(posedge clk_i)
  begin
    if (hdr_enq)
    begin
      hdr_mem[hdr_wr_ptr_r] <= msg_header_i;
    end
    if (enq)
    begin
      data_mem[data_wr_ptr_r] <= '{last: msg_last_i, data: msg_data_i};
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      hdr_wr_ptr_r  <= '0;
      hdr_rd_ptr_r  <= '0;
      data_wr_ptr_r <= '0;
      data_rd_ptr_r <= '0;
      hdr_cnt_r     <= '0;
      data_cnt_r    <= '0;
      in_msg_r      <= 1'b0;
    end
    else
    begin
      // set after a non-last beat, cleared once the last beat is taken
      if (enq)
      begin
        in_msg_r <= ~msg_last_i;
      end
      if (hdr_enq)
      begin
        hdr_wr_ptr_r <= (hdr_wr_ptr_r == hdr_ptr_w'(hdr_els_p - 1)) ? '0 : hdr_wr_ptr_r + 1'b1;
      end
      if (hdr_deq)
      begin
        hdr_rd_ptr_r <= (hdr_rd_ptr_r == hdr_ptr_w'(hdr_els_p - 1)) ? '0 : hdr_rd_ptr_r + 1'b1;
      end
      if (enq)
      begin
        data_wr_ptr_r <= (data_wr_ptr_r == data_ptr_w'(data_els_p - 1)) ? '0 : data_wr_ptr_r + 1'b1;
      end
      if (deq)
      begin
        data_rd_ptr_r <= (data_rd_ptr_r == data_ptr_w'(data_els_p - 1)) ? '0 : data_rd_ptr_r + 1'b1;
      end
      // occupancy moves only when one side acts alone
      if (hdr_enq & ~hdr_deq)
      begin
        hdr_cnt_r <= hdr_cnt_r + 1'b1;
      end
      else if (~hdr_enq & hdr_deq)
      begin
        hdr_cnt_r <= hdr_cnt_r - 1'b1;
      end
      if (enq & ~deq)
      begin
        data_cnt_r <= data_cnt_r + 1'b1;
      end
      else if (~enq & deq)
      begin
        data_cnt_r <= data_cnt_r - 1'b1;
      end
    end
  end

endmodule

/* src/stream_pump_in.sv */
// buffers inbound request messages and presents them to a consumer FSM word by word
// reads are split 1:N, writes pass N:N, there is no N:1 path
// word addresses wrap inside the aligned group that the message size covers
`timescale 1ns/1ps
`include "stream_params.svh"

module stream_pump_in
  #(
    parameter int hdr_els_p  = `STREAM_HDR_ELS,
    parameter int data_els_p = `STREAM_DATA_ELS
  )
  (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  stream_pkg::msg_header_s  msg_header_i,
    input  stream_pkg::data_t        msg_data_i,
    input  logic                     msg_v_i,
    input  logic                     msg_last_i,
    output logic                     msg_ready_and_o,
    output stream_pkg::msg_header_s  fsm_header_o,
    output stream_pkg::addr_t        fsm_addr_o,
    output stream_pkg::data_t        fsm_data_o,
    output logic                     fsm_v_o,
    input  logic                     fsm_ready_and_i,
    output logic                     fsm_new_o,
    output logic                     fsm_last_o,
    output logic                     fsm_done_o
  );
  import stream_pkg::*;

  // byte offset bits inside one data beat
  localparam int off_w = $clog2(`STREAM_DATA_W / 8);

  msg_header_s fifo_header;
  data_t       fifo_data;
  logic        fifo_v, fifo_last, fifo_ready_and;

  beat_cnt_t first_cnt, last_cnt, num_stream, stream_cnt, wrap_cnt;
  beat_cnt_t cnt_r;
  logic      streaming_r;
  logic      is_rd, is_multi, is_last_cnt, last_beat, fire, cnt_up;

  stream_fifo
    #(
      .hdr_els_p  (hdr_els_p),
      .data_els_p (data_els_p)
    )
    fifo_inst
    (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .msg_header_i    (msg_header_i),
      .msg_data_i      (msg_data_i),
      .msg_v_i         (msg_v_i),
      .msg_last_i      (msg_last_i),
      .msg_ready_and_o (msg_ready_and_o),
      .msg_header_o    (fifo_header),
      .msg_data_o      (fifo_data),
      .msg_v_o         (fifo_v),
      .msg_last_o      (fifo_last),
      .msg_ready_and_i (fifo_ready_and)
    );

  always_comb
  begin
    // beats in the message minus one, sizes below a word count as one beat
    case (fifo_header.size)
      3'd4:    num_stream = beat_cnt_t'(1);
      3'd5:    num_stream = beat_cnt_t'(3);
      default: num_stream = '0;
    endcase

    // the critical word comes first, the count then runs up from it
    first_cnt = fifo_header.addr[off_w +: `STREAM_CNT_W];
    last_cnt  = first_cnt + num_stream;
    is_multi  = (num_stream != '0);
    is_rd     = (fifo_header.msg_type == e_msg_rd);

    // the first beat uses the address itself, later beats the counter
    stream_cnt  = streaming_r ? cnt_r : first_cnt;
    is_last_cnt = (stream_cnt == last_cnt) | ~is_multi;

    // a write ends where the stream says so, a read where the count runs out
    last_beat = is_rd ? is_last_cnt : fifo_last;

    // count bits inside the size come from the counter, the rest from the address
    wrap_cnt   = (stream_cnt & num_stream) | (first_cnt & ~num_stream);
    fsm_addr_o = {fifo_header.addr[`STREAM_ADDR_W-1:off_w+`STREAM_CNT_W],
                  wrap_cnt,
                  fifo_header.addr[off_w-1:0]};
  end

  // the header keeps the critical word address for the consumer
  assign fsm_header_o = fifo_header;
  assign fsm_data_o   = fifo_data;
  assign fsm_v_o      = fifo_v;

  // a read beat stays in the fifo until its last FSM beat is taken
  // a write beat is consumed on every FSM handshake
  assign fifo_ready_and = is_rd ? (is_last_cnt & fsm_ready_and_i) : fsm_ready_and_i;

  assign fire   = fsm_v_o & fsm_ready_and_i;
  assign cnt_up = fire & ~last_beat;

  assign fsm_new_o  = fire & ~streaming_r;
  assign fsm_done_o = fire & last_beat;
  assign fsm_last_o = fsm_v_o & last_beat;

  // the counter holds the next word index while a message is in flight
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      cnt_r       <= '0;
      streaming_r <= 1'b0;
    end
    else if (fsm_done_o)
    begin
      cnt_r       <= '0;
      streaming_r <= 1'b0;
    end
    else if (cnt_up)
    begin
      // first beat loads first+1, later beats step on from the counter
      cnt_r       <= stream_cnt + 1'b1;
      streaming_r <= 1'b1;
    end
  end

endmodule

/* src/stream_mem_ctrl.sv */
// word-addressed memory behind the pump, one response beat held at a time
// byte address bits [7:3] select the word, upper bits alias
// a write message gets one ack with zero data, a read one beat per word
`timescale 1ns/1ps
`include "stream_params.svh"

module stream_mem_ctrl
  (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  stream_pkg::msg_header_s  fsm_header_i,
    input  stream_pkg::addr_t        fsm_addr_i,
    input  stream_pkg::data_t        fsm_data_i,
    input  logic                     fsm_v_i,
    output logic                     fsm_ready_and_o,
    input  logic                     fsm_new_i,
    input  logic                     fsm_last_i,
    input  logic                     fsm_done_i,
    output stream_pkg::resp_header_s resp_header_o,
    output stream_pkg::data_t        resp_data_o,
    output logic                     resp_v_o,
    output logic                     resp_last_o,
    input  logic                     resp_ready_and_i
  );
  import stream_pkg::*;

  localparam int off_w  = $clog2(`STREAM_DATA_W / 8);
  localparam int word_w = $clog2(`STREAM_MEM_WORDS);

  data_t                 mem [`STREAM_MEM_WORDS];
  ctrl_state_e           state_r;
  addr_t                 msg_addr_r, ack_addr;
  logic [word_w-1:0]     word;
  logic                  fire, is_rd, wr_fire, produce, taken;

  // a new beat is taken when the response slot is free or being emptied
  assign resp_v_o        = (state_r == e_resp);
  assign taken           = resp_v_o & resp_ready_and_i;
  assign fsm_ready_and_o = (state_r == e_idle) | resp_ready_and_i;

  assign fire    = fsm_v_i & fsm_ready_and_o;
  assign is_rd   = (fsm_header_i.msg_type == e_msg_rd)
  ;
  assign wr_fire = fire & ~is_rd;
  assign word    = fsm_addr_i[off_w +: word_w];

  // every read beat answers, a write answers only on its done beat
  assign produce = fire & (is_rd | fsm_done_i);

  // single-beat writes see new and done together, so bypass the latch
  assign ack_addr = fsm_new_i ? fsm_header_i.addr : msg_addr_r;

  // memory starts out all zero
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < `STREAM_MEM_WORDS; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (wr_fire)
    begin
      mem[word] <= fsm_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r <= e_idle;
    end
    else if (produce)
    begin
      state_r <= e_resp;
    end
    else if (taken)
    begin
      state_r <= e_idle;
    end
  end

  // payload registers load with the beat, the state says when they are valid
  always_ff @(posedge clk_i)
  begin
    if (fire & fsm_new_i)
    begin
      msg_addr_r <= fsm_header_i.addr;
    end
    if (produce)
    begin
      if (is_rd)
      begin
        resp_header_o <= '{msg_type: e_msg_rd, addr: fsm_addr_i};
        resp_data_o   <= mem[word];
        resp_last_o   <= fsm_last_i;
      end
      else
      begin
        resp_header_o <= '{msg_type: e_msg_wr, addr: ack_addr};
        resp_data_o   <= '0;
        resp_last_o   <= 1'b1;
      end
    end
  end

endmodule

/* src/stream_mem_top.sv */
// memory endpoint, request stream in and response stream out
// latency depends on response back-pressure and buffer occupancy
`timescale 1ns/1ps

module stream_mem_top
  (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  stream_pkg::msg_header_s  req_header_i,
    input  stream_pkg::data_t        req_data_i,
    input  logic                     req_v_i,
    input  logic                     req_last_i,
    output logic                     req_ready_and_o,
    output stream_pkg::resp_header_s resp_header_o,
    output stream_pkg::data_t        resp_data_o,
    output logic                     resp_v_o,
    output logic                     resp_last_o,
    input  logic                     resp_ready_and_i
  );
  import stream_pkg::*;

  // FSM port between the pump and the memory controller
  msg_header_s fsm_header;
  addr_t       fsm_addr;
  data_t       fsm_data;
  logic        fsm_v, fsm_ready_and, fsm_new, fsm_last, fsm_done;

  stream_pump_in pump_inst
    (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .msg_header_i    (req_header_i),
      .msg_data_i      (req_data_i),
      .msg_v_i         (req_v_i),
      .msg_last_i      (req_last_i),
      .msg_ready_and_o (req_ready_and_o),
      .fsm_header_o    (fsm_header),
      .fsm_addr_o      (fsm_addr),
      .fsm_data_o      (fsm_data),
      .fsm_v_o         (fsm_v),
      .fsm_ready_and_i (fsm_ready_and),
      .fsm_new_o       (fsm_new),
      .fsm_last_o      (fsm_last),
      .fsm_done_o      (fsm_done)
    );

  stream_mem_ctrl ctrl_inst
    (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .fsm_header_i     (fsm_header),
      .fsm_addr_i       (fsm_addr),
      .fsm_data_i       (fsm_data),
      .fsm_v_i          (fsm_v),
      .fsm_ready_and_o  (fsm_ready_and),
      .fsm_new_i        (fsm_new),
      .fsm_last_i       (fsm_last),
      .fsm_done_i       (fsm_done),
      .resp_header_o    (resp_header_o),
      .resp_data_o      (resp_data_o),
      .resp_v_o         (resp_v_o),
      .resp_last_o      (resp_last_o),
      .resp_ready_and_i (resp_ready_and_i)
    );

endmodule

/* verif/stream_mem_assert.sv */
// protocol checks on the inbound pump, attached by bind to stream_pump_in
// all checks are off while rst_i is high
// beat counts assume every message carries as many words as its size covers
`timescale 1ns/1ps

module stream_mem_assert
  (
    input logic                    clk_i,
    input logic                    rst_i,
    input stream_pkg::msg_header_s msg_header_i,
    input stream_pkg::data_t       msg_data_i,
    input logic                    msg_v_i,
    input logic                    msg_last_i,
    input logic                    msg_ready_and_i,
    input stream_pkg::msg_header_s fsm_header_i,
    input stream_pkg::addr_t       fsm_addr_i,
    input stream_pkg::data_t       fsm_data_i,
    input logic                    fsm_v_i,
    input logic                    fsm_ready_and_i,
    input logic                    fsm_new_i,
    input logic                    fsm_last_i,
    input logic                    fsm_done_i,
    input logic                    streaming_i
  );

  // FSM beats already handed over in the current message
  logic [3:0] taken_r;
  // words a message of this size covers, one per 8 bytes
  logic [3:0] msg_beats;

  assign msg_beats = 4'd1 << (fsm_header_i.size - 3'd3);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      taken_r <= '0;
    end
    else if (fsm_done_i)
    begin
      taken_r <= '0;
    end
    else if (fsm_v_i && fsm_ready_and_i)
    begin
      taken_r <= taken_r + 1'b1;
    end
  end

  // a stalled request beat must stay put until the fifo takes it
  req_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    msg_v_i && !msg_ready_and_i |=> msg_v_i && $stable(msg_header_i)
      && $stable(msg_data_i) && $stable(msg_last_i))
    else $error("request beat changed while it was stalled");

  // the same holds for the beat offered to the consumer FSM
  fsm_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    fsm_v_i && !fsm_ready_and_i |=> fsm_v_i && $stable(fsm_addr_i)
      && $stable(fsm_data_i) && $stable(fsm_last_i))
    else $error("FSM beat changed while it was stalled");

  // done is the handshake of the last beat, after exactly one beat per word
  done_last_a: assert property (@(posedge clk_i) disable iff (rst_i)
    fsm_done_i |-> fsm_last_i && (taken_r + 4'd1 == msg_beats))
    else $error("fsm_done without fsm_last or after the wrong number of beats");

  // once a beat of the message is taken the pump streams and new stays low
  new_stream_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (taken_r != '0) |-> streaming_i && !fsm_new_i)
    else $error("fsm_new raised in the middle of a message");

  // the first handshake of every message carries new
  new_first_a: assert property (@(posedge clk_i) disable iff (rst_i)
    fsm_v_i && fsm_ready_and_i && (taken_r == '0) |-> fsm_new_i)
    else $error("first beat of a message handed over without fsm_new");

endmodule

/* verif/stream_mem_tb.sv */
// drives request messages from the vectors file and checks every response beat in order
// the vectors file is read relative to the project root
// back-pressure comes from the LFSR only for lines marked with the bp flag
`timescale 1ns/1ps

module stream_mem_tb;
  import stream_pkg::*;

  localparam int vec_max = 64;

  logic         clk_i = 1'b0;
  logic         rst_i = 1'b1;
  msg_header_s  req_header_i = '0;
  data_t        req_data_i = '0;
  logic         req_v_i = 1'b0;
  logic         req_last_i = 1'b0;
  logic         req_ready_and_o;
  resp_header_s resp_header_o;
  data_t        resp_data_o;
  logic         resp_v_o;
  logic         resp_last_o;
  logic         resp_ready_and_i = 1'b0;

  // each line packs kind, bp, type, addr, size, data and last into 100 bits
  logic [99:0]  vec_mem [vec_max];
  logic [99:0]  req_q [$];
  logic [99:0]  exp_q [$];
  int           exp_idx = 0;
  int           cycle_cnt = 0;
  int           cycle_limit = 1000;
  logic [31:0]  lfsr_r = 32'h02b303b7;

  stream_mem_top stream_mem_top_inst
    (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .req_header_i     (req_header_i),
      .req_data_i       (req_data_i),
      .req_v_i          (req_v_i),
      .req_last_i       (req_last_i),
      .req_ready_and_o  (req_ready_and_o),
      .resp_header_o    (resp_header_o),
      .resp_data_o      (resp_data_o),
      .resp_v_o         (resp_v_o),
      .resp_last_o      (resp_last_o),
      .resp_ready_and_i (resp_ready_and_i)
    );

  bind stream_pump_in stream_mem_assert assert_inst
    (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .msg_header_i    (msg_header_i),
      .msg_data_i      (msg_data_i),
      .msg_v_i         (msg_v_i),
      .msg_last_i      (msg_last_i),
      .msg_ready_and_i (msg_ready_and_o),
      .fsm_header_i    (fsm_header_o),
      .fsm_addr_i      (fsm_addr_o),
      .fsm_data_i      (fsm_data_o),
      .fsm_v_i         (fsm_v_o),
      .fsm_ready_and_i (fsm_ready_and_i),
      .fsm_new_i       (fsm_new_o),
      .fsm_last_i      (fsm_last_o),
      .fsm_done_i      (fsm_done_o),
      .streaming_i     (streaming_r)
    );

  always #2 clk_i = ~clk_i;

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0])
    begin
      next = next ^ 32'h80200003;
    end
    return next;
  endfunction

  task automatic stop_run(input string reason);
    $display("ERROR: %s", reason);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "response mismatch");
    end
  endtask

  // compares the accepted beat with the next expected line
  task automatic check_response();
    logic [99:0] vec;
    if (exp_idx >= exp_q.size())
    begin
      stop_run("a response beat arrived after all expected beats were seen");
    end
    else
    begin
      vec = exp_q[exp_idx];
      check_value("resp_header_o.msg_type", 64'(resp_header_o.msg_type), 64'(vec[91:88]));
      check_value("resp_header_o.addr", 64'(resp_header_o.addr), 64'(vec[87:72]));
      check_value("resp_data_o", resp_data_o, vec[67:4]);
      check_value("resp_last_o", 64'(resp_last_o), 64'(vec[3:0]));
      exp_idx = exp_idx + 1;
    end
  endtask

  // splits the file into request beats and expected responses
  task automatic load_vectors();
    int n;
    $readmemh("verif/stream_mem_vectors.txt", vec_mem);
    n = 0;
    // unfilled lines read as unknown and are caught as a bad kind
    while (n < vec_max && vec_mem[n][99:96] !== 4'hf)
    begin
      case (vec_mem[n][99:96])
        4'h0: req_q.push_back(vec_mem[n]);
        4'h1: exp_q.push_back(vec_mem[n]);
        default: stop_run("the vectors file holds a line of unknown kind");
      endcase
      n++;
    end
    if (n == vec_max)
    begin
      stop_run("the vectors file has no end marker");
    end
    else
    begin
      cycle_limit = 40 * (n + 1);
    end
  endtask

  // holds one request beat until the fifo accepts it
  task automatic send_beat(input logic [99:0] vec);
    req_header_i <= '{msg_type: msg_type_e'(vec[88]), addr: vec[87:72], size: vec[70:68]};
    req_data_i   <= vec[67:4];
    req_last_i   <= vec[0];
    req_v_i      <= 1'b1;
    @(posedge clk_i);
    while (!req_ready_and_o)
    begin
      @(posedge clk_i);
    end
  endtask

  initial
  begin
    load_vectors();
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    // requests go in back to back, responses are checked as they come
    for (int i = 0; i < req_q.size(); i++)
    begin
      send_beat(req_q[i]);
    end
    req_v_i <= 1'b0;
    while (exp_idx < exp_q.size())
    begin
      @(posedge clk_i);
    end
    // a few idle cycles catch any extra response beat
    repeat (10) @(posedge clk_i);
    $display(">>> PASS");
    $finish;
  end

  always @(posedge clk_i)
  begin
    if (rst_i)
    begin
      resp_ready_and_i <= 1'b0;
    end
    else
    begin
      if (resp_v_o && resp_ready_and_i)
      begin
        check_response();
      end
      // back-pressure follows the test that owns the next expected beat
      if (exp_idx < exp_q.size() && exp_q[exp_idx][95:92] != 4'h0)
      begin
        resp_ready_and_i <= lfsr_r[0];
        lfsr_r = lfsr_step(lfsr_r);
      end
      else
      begin
        resp_ready_and_i <= 1'b1;
      end
    end
  end

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      stop_run("timeout, the expected responses did not all arrive in time");
    end
  end

endmodule

/* compile.f */
+incdir+src
src/stream_pkg.sv
src/stream_fifo.sv
src/stream_pump_in.sv
src/stream_mem_ctrl.sv
src/stream_mem_top.sv
verif/stream_mem_assert.sv
verif/stream_mem_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module stream_mem_tb -Mdir obj_dir -f compile.f

# the simulator exit code is not trusted, the output decides
out=$(./obj_dir/Vstream_mem_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* verif/stream_mem_vectors.txt */
// kind_bp_type_addr_size_data_last, kind 0 = request beat, 1 = expected response, f = end
// bp 1 puts random back-pressure on the response stream, type 0 = read, 1 = write
// write 32 bytes to words 8..11, one ack, then read the block back in order
0_0_1_0040_5_00000000c0de0008_0
0_0_1_0040_5_00000000c0de0009_0
0_0_1_0040_5_00000000c0de000a_0
0_0_1_0040_5_00000000c0de000b_1
1_0_1_0040_0_0000000000000000_1
0_0_0_0040_5_0000000000000000_1
1_0_0_0040_0_00000000c0de0008_0
1_0_0_0048_0_00000000c0de0009_0
1_0_0_0050_0_00000000c0de000a_0
1_0_0_0058_0_00000000c0de000b_1
// 32-byte read at word 2 wraps 2, 3, 0, 1 and keeps the low address bits
0_0_0_0053_5_0000000000000000_1
1_0_0_0053_0_00000000c0de000a_0
1_0_0_005b_0_00000000c0de000b_0
1_0_0_0043_0_00000000c0de0008_0
1_0_0_004b_0_00000000c0de0009_1
// 16-byte read at word 3 wraps to word 2, 8-byte read is a single beat
0_0_0_0058_4_0000000000000000_1
1_0_0_0058_0_00000000c0de000b_0
1_0_0_0050_0_00000000c0de000a_1
0_0_0_0048_3_0000000000000000_1
1_0_0_0048_0_00000000c0de0009_1
// single-word write to word 21, its neighbours stay zero and block 8 is untouched
0_0_1_00a8_3_1234567800000015_1
1_0_1_00a8_0_0000000000000000_1
0_0_0_00a0_5_0000000000000000_1
1_0_0_00a0_0_0000000000000000_0
1_0_0_00a8_0_1234567800000015_0
1_0_0_00b0_0_0000000000000000_0
1_0_0_00b8_0_0000000000000000_1
0_0_0_0048_3_0000000000000000_1
1_0_0_0048_0_00000000c0de0009_1
// back to back under back-pressure, the 16-byte write at word 13 wraps to word 12
0_1_1_0068_4_fedcba980000000d_0
0_1_1_0068_4_fedcba980000000c_1
1_1_1_0068_0_0000000000000000_1
0_1_0_0060_5_0000000000000000_1
1_1_0_0060_0_fedcba980000000c_0
1_1_0_0068_0_fedcba980000000d_0
1_1_0_0070_0_0000000000000000_0
1_1_0_0078_0_0000000000000000_1
0_1_0_0048_5_0000000000000000_1
1_1_0_0048_0_00000000c0de0009_0
1_1_0_0050_0_00000000c0de000a_0
1_1_0_0058_0_00000000c0de000b_0
1_1_0_0040_0_00000000c0de0008_1
f_0_0_0000_0_0000000000000000_0
